//--- bench/gbc_io_model.svh
`ifndef GBC_IO_MODEL_SVH
`define GBC_IO_MODEL_SVH

// Reference view of the memory map, kept in step with every bus write
localparam addr_t WRAM_LAST = addr_t'(WRAM_BASE + WRAM_DEPTH - 1);

byte_t    wram_shadow [WRAM_DEPTH];
addr_t    wram_written [$];
byte_t    sc_shadow;
byte_t    sb_shadow;
byte_t    rp_shadow;
byte_t    key1_shadow;
byte_t    tma_shadow;
logic [2:0] tac_shadow;
irq_vec_t if_shadow;
irq_vec_t ie_shadow;

function automatic void reset_model();
   sc_shadow   = RST_SC;
   sb_shadow   = RST_SB;
   rp_shadow   = RST_RP;
   key1_shadow = RST_KEY1;
   tma_shadow  = 8'h00;
   tac_shadow  = RST_TAC[2:0];
   if_shadow   = '0;
   ie_shadow   = '0;
   wram_written.delete();
endfunction

function automatic bit in_wram(addr_t a);
   return (a >= WRAM_BASE) && (a <= WRAM_LAST);
endfunction

function automatic bit in_io(addr_t a);
   return ((a >= IO_BASE) && (a <= IO_LAST)) || (a == ADDR_IE);
endfunction

function automatic bit is_implemented(addr_t a);
   case (a)
      ADDR_SB, ADDR_SC, ADDR_DIV, ADDR_TIMA, ADDR_TMA, ADDR_TAC,
      ADDR_IF, ADDR_KEY1, ADDR_RP, ADDR_IE: return 1'b1;
      default: return 1'b0;
   endcase
endfunction

function automatic void apply_write(addr_t a, byte_t d);
   if (in_wram(a)) begin
      wram_shadow[a[WRAM_ADDR_BITS-1:0]] = d;
      wram_written.push_back(a);
   end else begin
      case (a)
         ADDR_SC:   sc_shadow   = d;
         ADDR_SB:   sb_shadow   = d;
         ADDR_RP:   rp_shadow   = d;
         ADDR_KEY1: key1_shadow = d;
         ADDR_TMA:  tma_shadow  = d;
         ADDR_TAC:  tac_shadow  = d[2:0];
         ADDR_IF:   if_shadow   = d[4:0];
         ADDR_IE:   ie_shadow   = d[4:0];
         default:   ;
      endcase
   end
endfunction

// DIV and TIMA run on their own and are checked by their tests
function automatic byte_t expected_read(addr_t a);
   if (in_wram(a))
      return wram_shadow[a[WRAM_ADDR_BITS-1:0]];
   if (!in_io(a))
      return OPEN_BUS;
   case (a)
      ADDR_SC:   return sc_shadow;
      ADDR_SB:   return sb_shadow;
      ADDR_RP:   return rp_shadow;
      ADDR_KEY1: return key1_shadow;
      ADDR_TMA:  return tma_shadow;
      ADDR_TAC:  return {5'b11111, tac_shadow};
      ADDR_IF:   return {3'b111, if_shadow};
      ADDR_IE:   return {3'b000, ie_shadow};
      default:   return 8'h00;
   endcase
endfunction

`endif

//--- bench/tb_gbc_io_top.sv
module tb_gbc_io_top;
   timeunit 1ns;
   timeprecision 100ps;
   import gbc_io_pkg::*;

   `include "gbc_io_model.svh"

   localparam int RANDOM_OPS  = 400;
   localparam int IRQ_ROUNDS  = 200;
   localparam int IRQ_TIMEOUT = 200;
   localparam int DIV_TIMEOUT = 600;

   logic  clock_in;
   logic  synch_reset;
   addr_t cpu_addr;
   byte_t cpu_wdata;
   logic  cpu_we_l;
   logic  cpu_re_l;
   byte_t cpu_rdata;
   logic  vblank_req;
   logic  lcdstat_req;
   logic  serial_req;
   logic  joypad_req;
   logic  irq_pending;

   int       error_count;
   int       check_count;
   int       tests_run;
   int       tests_failed;
   int       test_start_errors;
   int       op;
   int       n;
   int       tries;
   addr_t    a;
   byte_t    d;
   byte_t    tma_val;
   irq_vec_t ext;

   gbc_io_top dut (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .cpu_addr    (cpu_addr),
      .cpu_wdata   (cpu_wdata),
      .cpu_we_l    (cpu_we_l),
      .cpu_re_l    (cpu_re_l),
      .cpu_rdata   (cpu_rdata),
      .vblank_req  (vblank_req),
      .lcdstat_req (lcdstat_req),
      .serial_req  (serial_req),
      .joypad_req  (joypad_req),
      .irq_pending (irq_pending)
   );

   always #4 clock_in = ~clock_in;

   // ======================================================================
   // Bus access and compare tasks
   // ======================================================================
   task automatic next_cycle();
      @(posedge clock_in);
      #1;
   endtask

   task automatic bus_write(input addr_t wa, input byte_t wd);
      cpu_addr  = wa;
      cpu_wdata = wd;
      cpu_we_l  = 1'b0;
      next_cycle();
      cpu_we_l = 1'b1;
      apply_write(wa, wd);
   endtask

   // Data is sampled one clock after the strobe cycle
   task automatic bus_read(input addr_t ra, output byte_t rd);
      cpu_addr = ra;
      cpu_re_l = 1'b0;
      next_cycle();
      cpu_re_l = 1'b1;
      rd = cpu_rdata;
   endtask

   task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED at %0t ns: %s read %02h, expected %02h",
                  $time, what, actual, expected);
      end
   endtask

   task automatic check_level(input logic actual, input logic expected, input string what);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED at %0t ns: %s is %b, expected %b",
                  $time, what, actual, expected);
      end
   endtask

   task automatic read_and_check(input addr_t ra, input string what);
      byte_t rd;
      bus_read(ra, rd);
      check_byte(rd, expected_read(ra), $sformatf("%s at %04h", what, ra));
   endtask

   task automatic report_timeout(input string what);
      error_count++;
      $display("Timeout at %0t ns: %s", $time, what);
   endtask

   task automatic pulse_requests(input irq_vec_t req);
      vblank_req  = req[IRQ_VBLANK];
      lcdstat_req = req[IRQ_LCDSTAT];
      serial_req  = req[IRQ_SERIAL];
      joypad_req  = req[IRQ_JOYPAD];
      next_cycle();
      {vblank_req, lcdstat_req, serial_req, joypad_req} = '0;
      if_shadow = if_shadow | req;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (error_count == test_start_errors) begin
         $display("Test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", tests_run, name,
                  error_count - test_start_errors);
      end
      test_start_errors = error_count;
   endtask

   function automatic addr_t storage_addr(int sel);
      case (sel)
         0:       return ADDR_SC;
         1:       return ADDR_SB;
         2:       return ADDR_RP;
         default: return ADDR_KEY1;
      endcase
   endfunction

   // ======================================================================
   // Test sequence
   // ======================================================================
   initial begin
      clock_in    = 1'b0;
      synch_reset = 1'b1;
      cpu_addr    = '0;
      cpu_wdata   = '0;
      cpu_we_l    = 1'b1;
      cpu_re_l    = 1'b1;
      vblank_req  = 1'b0;
      lcdstat_req = 1'b0;
      serial_req  = 1'b0;
      joypad_req  = 1'b0;
      error_count       = 0;
      check_count       = 0;
      tests_run         = 0;
      tests_failed      = 0;
      test_start_errors = 0;
      void'($urandom(32'hc2b6_eb6b));
      reset_model();
      repeat (4) @(posedge clock_in);
      #1;
      synch_reset = 1'b0;

      // Reset values
      check_level(irq_pending, 1'b0, "irq_pending after reset");
      read_and_check(ADDR_SC, "SC");
      read_and_check(ADDR_SB, "SB");
      read_and_check(ADDR_KEY1, "KEY1");
      read_and_check(ADDR_RP, "RP");
      read_and_check(ADDR_TAC, "TAC");
      read_and_check(ADDR_IF, "IF");
      read_and_check(ADDR_IE, "IE");
      finish_test("reset values");

      // Random traffic over WRAM, storage registers and unmapped space
      for (int i = 0; i < RANDOM_OPS; i++) begin
         op = $urandom_range(0, 5);
         if (op == 1 && wram_written.size() == 0)
            op = 0;
         case (op)
            0: bus_write(addr_t'(WRAM_BASE + $urandom_range(0, WRAM_DEPTH - 1)),
                         byte_t'($urandom));
            1: read_and_check(wram_written[$urandom_range(0, wram_written.size() - 1)],
                              "WRAM");
            2: bus_write(storage_addr($urandom_range(0, 3)), byte_t'($urandom));
            3: read_and_check(storage_addr($urandom_range(0, 3)), "storage register");
            4: begin
               case ($urandom_range(0, 2))
                  0:       a = addr_t'($urandom_range(0, 16'hBFFF));
                  1:       a = addr_t'($urandom_range(16'hE000, 16'hFEFF));
                  default: a = addr_t'($urandom_range(16'hFF80, 16'hFFFE));
               endcase
               bus_write(a, byte_t'($urandom));
               read_and_check(a, "unmapped");
            end
            default: begin
               n = $urandom_range(0, 127);
               while (is_implemented(addr_t'(IO_BASE + n)))
                  n = (n + 1) % 128;
               bus_write(addr_t'(IO_BASE + n), byte_t'($urandom));
               read_and_check(addr_t'(IO_BASE + n), "unimplemented IO");
            end
         endcase
      end
      finish_test("random memory map");

      // DIV clear, then the counter only moves forward
      bus_write(ADDR_DIV, byte_t'($urandom));
      bus_read(ADDR_DIV, d);
      check_byte(d, 8'h00, "DIV right after clear");
      tries = 0;
      while (d == 8'h00 && tries < DIV_TIMEOUT) begin
         bus_read(ADDR_DIV, d);
         tries++;
      end
      // Reads come every clock, so the first step seen is one count
      if (d == 8'h00)
         report_timeout("DIV did not advance after the clear");
      else
         check_byte(d, 8'h01, "DIV on first advance");
      finish_test("DIV clear");

      // TIMA overflow into the timer interrupt
      bus_write(ADDR_IF, 8'h00);
      bus_write(ADDR_IE, 8'h04);
      tma_val = byte_t'($urandom);
      bus_write(ADDR_TMA, tma_val);
      bus_write(ADDR_TIMA, 8'hFF);
      bus_write(ADDR_TAC, 8'h05);
      tries = 0;
      while (!irq_pending && tries < IRQ_TIMEOUT) begin
         next_cycle();
         tries++;
      end
      if (!irq_pending) begin
         report_timeout("irq_pending never rose after TIMA overflow");
      end else begin
         bus_read(ADDR_IF, d);
         check_byte(d & 8'h04, 8'h04, "IF timer bit");
         // Next TIMA step is a full period after the reload
         bus_read(ADDR_TIMA, d);
         check_byte(d, tma_val, "TIMA after reload");
      end
      // Let any request already in flight land before clearing IF
      bus_write(ADDR_TAC, 8'h00);
      next_cycle();
      next_cycle();
      bus_write(ADDR_IF, 8'h00);
      check_level(irq_pending, 1'b0, "irq_pending with timer stopped");
      finish_test("timer overflow");

      // External requests, masking and acknowledge
      for (int i = 0; i < IRQ_ROUNDS; i++) begin
         ext = irq_vec_t'($urandom);
         ext[IRQ_TIMER] = 1'b0;
         pulse_requests(ext);
         case ($urandom_range(0, 2))
            0:       bus_write(ADDR_IE, byte_t'($urandom));
            1:       bus_write(ADDR_IF, byte_t'($urandom));
            default: ;
         endcase
         check_level(irq_pending, |(if_shadow & ie_shadow), "irq_pending");
         read_and_check(ADDR_IF, "IF");
      end
      bus_write(ADDR_IE, 8'h1F);
      pulse_requests(irq_vec_t'(1 << IRQ_JOYPAD));
      check_level(irq_pending, 1'b1, "irq_pending on joypad request");
      bus_write(ADDR_IF, 8'h00);
      check_level(irq_pending, 1'b0, "irq_pending after IF cleared");
      finish_test("interrupt requests");

      $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- gbc_io_top.f
+incdir+bench
verilog/gbc_io_pkg.sv
verilog/io_bus_if.sv
verilog/memory_router.sv
verilog/work_ram.sv
verilog/timer_unit.sv
verilog/interrupt_unit.sv
verilog/misc_io_regs.sv
verilog/gbc_io_top.sv
bench/tb_gbc_io_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f gbc_io_top.f --top-module tb_gbc_io_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
   exit 1
fi
exit 0

//--- verilog/gbc_io_pkg.sv
package gbc_io_pkg;

   // ======================================================================
   // Bus types
   // ======================================================================
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [4:0]  irq_vec_t;

   // ======================================================================
   // Address map
   // ======================================================================
   localparam addr_t WRAM_BASE      = 16'hC000;
   localparam int    WRAM_DEPTH     = 8192;
   localparam int    WRAM_ADDR_BITS = 13;

   // IO window, IE sits alone at the top of the map
   localparam addr_t IO_BASE = 16'hFF00;
   localparam addr_t IO_LAST = 16'hFF7F;

   // Register addresses
   localparam addr_t ADDR_SB   = 16'hFF01;
   localparam addr_t ADDR_SC   = 16'hFF02;
   localparam addr_t ADDR_DIV  = 16'hFF04;
   localparam addr_t ADDR_TIMA = 16'hFF05;
   localparam addr_t ADDR_TMA  = 16'hFF06;
   localparam addr_t ADDR_TAC  = 16'hFF07;
   localparam addr_t ADDR_IF   = 16'hFF0F;
   localparam addr_t ADDR_KEY1 = 16'hFF4D;
   localparam addr_t ADDR_RP   = 16'hFF56;
   localparam addr_t ADDR_IE   = 16'hFFFF;

   // Power-on values
   localparam byte_t RST_SC   = 8'h7C;
   localparam byte_t RST_SB   = 8'h00;
   localparam byte_t RST_KEY1 = 8'hFD;
   localparam byte_t RST_RP   = 8'h3E;
   localparam byte_t RST_TAC  = 8'hF8;

   // ======================================================================
   // Interrupt sources, bit positions in IF and IE
   // ======================================================================
   localparam int IRQ_VBLANK  = 0;
   localparam int IRQ_LCDSTAT = 1;
   localparam int IRQ_TIMER   = 2;
   localparam int IRQ_SERIAL  = 3;
   localparam int IRQ_JOYPAD  = 4;

   // Value seen on reads of unmapped regions
   localparam byte_t OPEN_BUS = 8'hFF;

endpackage

//--- verilog/gbc_io_top.sv
module gbc_io_top (
   input  logic              clock_in,
   input  logic              synch_reset,
   input  gbc_io_pkg::addr_t cpu_addr,
   input  gbc_io_pkg::byte_t cpu_wdata,
   input  logic              cpu_we_l,
   input  logic              cpu_re_l,
   output gbc_io_pkg::byte_t cpu_rdata,
   input  logic              vblank_req,
   input  logic              lcdstat_req,
   input  logic              serial_req,
   input  logic              joypad_req,
   output logic              irq_pending
);
   import gbc_io_pkg::*;

   io_bus_if bus ();

   byte_t                     rdata_timer;
   byte_t                     rdata_irq;
   byte_t                     rdata_misc;
   logic [WRAM_ADDR_BITS-1:0] ram_addr;
   byte_t                     ram_wdata;
   logic                      ram_we_l;
   byte_t                     ram_rdata;
   logic                      timer_req;
   irq_vec_t                  irq_req;

   // ======================================================================
   // Interrupt source collection
   // ======================================================================
   assign irq_req[IRQ_VBLANK]  = vblank_req;
   assign irq_req[IRQ_LCDSTAT] = lcdstat_req;
   assign irq_req[IRQ_TIMER]   = timer_req;
   assign irq_req[IRQ_SERIAL]  = serial_req;
   assign irq_req[IRQ_JOYPAD]  = joypad_req;

   memory_router u_router (
      .clock_in       (clock_in),
      .synch_reset    (synch_reset),
      .cpu_addr       (cpu_addr),
      .cpu_wdata      (cpu_wdata),
      .cpu_we_l       (cpu_we_l),
      .cpu_re_l       (cpu_re_l),
      .cpu_rdata      (cpu_rdata),
      .io             (bus.router),
      .io_rdata_timer (rdata_timer),
      .io_rdata_irq   (rdata_irq),
      .io_rdata_misc  (rdata_misc),
      .ram_addr       (ram_addr),
      .ram_wdata      (ram_wdata),
      .ram_we_l       (ram_we_l),
      .ram_rdata      (ram_rdata)
   );

   work_ram u_wram (
      .clock_in (clock_in),
      .addr     (ram_addr),
      .wdata    (ram_wdata),
      .we_l     (ram_we_l),
      .rdata    (ram_rdata)
   );

   timer_unit u_timer (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io          (bus.target),
      .rdata       (rdata_timer),
      .timer_req   (timer_req)
   );

   interrupt_unit u_irq (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io          (bus.target),
      .req         (irq_req),
      .rdata       (rdata_irq),
      .irq_pending (irq_pending)
   );

   misc_io_regs u_misc (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io          (bus.target),
      .rdata       (rdata_misc)
   );

endmodule

//--- verilog/interrupt_unit.sv
module interrupt_unit (
   input  logic                 clock_in,
   input  logic                 synch_reset,
   io_bus_if.target             io,
   input  gbc_io_pkg::irq_vec_t req,
   output gbc_io_pkg::byte_t    rdata,
   output logic                 irq_pending
);
   import gbc_io_pkg::*;

   irq_vec_t if_q;
   irq_vec_t ie_q;
   logic     wr_if;
   logic     wr_ie;

   assign wr_if = !io.we_l && (io.addr == ADDR_IF);
   assign wr_ie = !io.we_l && (io.addr == ADDR_IE);

   // ======================================================================
   // Flag and enable registers
   // ======================================================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         if_q <= '0;
         ie_q <= '0;
      end else begin
         // CPU ack by writing IF, new requests are never lost
         if (wr_if)
            if_q <= io.wdata[4:0] | req;
         else
            if_q <= if_q | req;

         if (wr_ie) begin
            ie_q <= io.wdata[4:0];
         end
      end
   end

   assign irq_pending = |(if_q & ie_q);

   always_comb begin
      rdata = '0;
      if (!io.re_l) begin
         if (io.addr == ADDR_IF)
            rdata = {3'b111, if_q};
         else if (io.addr == ADDR_IE)
            rdata = {3'b000, ie_q};
      end
   end

   // Pending only rises after a new request or a write to IF or IE
   a_pending_has_cause: assert property (
      @(posedge clock_in) disable iff (synch_reset)
         $rose(irq_pending) |-> $past((req != '0) || wr_if || wr_ie)
   );

endmodule

//--- verilog/io_bus_if.sv
interface io_bus_if;
   import gbc_io_pkg::*;

   addr_t addr;
   byte_t wdata;
   // Active-low strobes, already gated to the IO region
   logic  we_l;
   logic  re_l;

   modport router (
      output addr,
      output wdata,
      output we_l,
      output re_l
   );

   modport target (
      input addr,
      input wdata,
      input we_l,
      input re_l
   );

endinterface

//--- verilog/memory_router.sv
module memory_router (
   input  logic                                 clock_in,
   input  logic                                 synch_reset,
   input  gbc_io_pkg::addr_t                    cpu_addr,
   input  gbc_io_pkg::byte_t                    cpu_wdata,
   input  logic                                 cpu_we_l,
   input  logic                                 cpu_re_l,
   output gbc_io_pkg::byte_t                    cpu_rdata,
   io_bus_if.router                             io,
   input  gbc_io_pkg::byte_t                    io_rdata_timer,
   input  gbc_io_pkg::byte_t                    io_rdata_irq,
   input  gbc_io_pkg::byte_t                    io_rdata_misc,
   output logic [gbc_io_pkg::WRAM_ADDR_BITS-1:0] ram_addr,
   output gbc_io_pkg::byte_t                    ram_wdata,
   output logic                                 ram_we_l,
   input  gbc_io_pkg::byte_t                    ram_rdata
);
   import gbc_io_pkg::*;

   typedef enum logic [1:0] {
      SRC_OPEN,
      SRC_RAM,
      SRC_IO
   } rd_src_e;

   logic    is_wram;
   logic    is_io;
   rd_src_e region;
   rd_src_e rd_src;
   logic    rd_valid;
   byte_t   io_q;
   byte_t   hold_q;
   byte_t   sel_data;

   // ======================================================================
   // Region decode
   // ======================================================================
   assign is_wram = (cpu_addr[15:WRAM_ADDR_BITS] == WRAM_BASE[15:WRAM_ADDR_BITS]);
   assign is_io   = ((cpu_addr >= IO_BASE) && (cpu_addr <= IO_LAST)) ||
                    (cpu_addr == ADDR_IE);

   always_comb begin
      if (is_wram)
         region = SRC_RAM;
      else if (is_io)
         region = SRC_IO;
      else
         region = SRC_OPEN;
   end

   // Strobes only reach the region that owns the address
   assign io.addr  = cpu_addr;
   assign io.wdata = cpu_wdata;
   assign io.we_l  = cpu_we_l | ~is_io;
   assign io.re_l  = cpu_re_l | ~is_io;

   assign ram_addr  = cpu_addr[WRAM_ADDR_BITS-1:0];
   assign ram_wdata = cpu_wdata;
   assign ram_we_l  = cpu_we_l | ~is_wram;

   // ======================================================================
   // Read return path
   // ======================================================================
   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         rd_valid <= 1'b0;
         rd_src   <= SRC_OPEN;
         hold_q   <= OPEN_BUS;
      end else begin
         rd_valid <= ~cpu_re_l;
         if (!cpu_re_l) begin
            rd_src <= region;
         end
         // Keep the last returned byte once RAM moves on
         if (rd_valid) begin
            hold_q <= sel_data;
         end
      end
   end

   // Unowned IO addresses give zero from every target
   always_ff @(posedge clock_in) begin
      if (!cpu_re_l) begin
         io_q <= io_rdata_timer | io_rdata_irq | io_rdata_misc;
      end
   end

   always_comb begin
      case (rd_src)
         SRC_RAM: sel_data = ram_rdata;
         SRC_IO:  sel_data = io_q;
         default: sel_data = OPEN_BUS;
      endcase
   end

   assign cpu_rdata = rd_valid ? sel_data : hold_q;

   // CPU side never reads and writes in one cycle
   a_no_dual_strobe: assert property (
      @(posedge clock_in) disable iff (synch_reset) !(!cpu_we_l && !cpu_re_l)
   );

endmodule

//--- verilog/misc_io_regs.sv
module misc_io_regs (
   input  logic              clock_in,
   input  logic              synch_reset,
   io_bus_if.target          io,
   output gbc_io_pkg::byte_t rdata
);
   import gbc_io_pkg::*;

   localparam int NUM_REGS = 4;

   // Serial control, serial data, infrared port, speed switch
   localparam addr_t REG_ADDR [NUM_REGS] = '{ADDR_SC, ADDR_SB, ADDR_RP, ADDR_KEY1};
   localparam byte_t REG_RST  [NUM_REGS] = '{RST_SC, RST_SB, RST_RP, RST_KEY1};

   byte_t regs [NUM_REGS];

   always_ff @(posedge clock_in) begin
      for (int i = 0; i < NUM_REGS; i++) begin
         if (synch_reset)
            regs[i] <= REG_RST[i];
         else if (!io.we_l && (io.addr == REG_ADDR[i]))
            regs[i] <= io.wdata;
      end
   end

   always_comb begin
      rdata = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         if (!io.re_l && (io.addr == REG_ADDR[i])) begin
            rdata = regs[i];
         end
      end
   end

endmodule

//--- verilog/timer_unit.sv
module timer_unit (
   input  logic              clock_in,
   input  logic              synch_reset,
   io_bus_if.target          io,
   output gbc_io_pkg::byte_t rdata,
   output logic              timer_req
);
   import gbc_io_pkg::*;

   logic [15:0] sys_cnt;
   byte_t       tima;
   byte_t       tma;
   logic [2:0]  tac;
   logic [9:0]  step_mask;
   logic        step;
   logic        wr_div;
   logic        wr_tima;
   logic        wr_tma;
   logic        wr_tac;

   assign wr_div  = !io.we_l && (io.addr == ADDR_DIV);
   assign wr_tima = !io.we_l && (io.addr == ADDR_TIMA);
   assign wr_tma  = !io.we_l && (io.addr == ADDR_TMA);
   assign wr_tac  = !io.we_l && (io.addr == ADDR_TAC);

   // ======================================================================
   // TIMA step rate, TAC[1:0] picks 1024, 16, 64 or 256 clocks
   // ======================================================================
   always_comb begin
      case (tac[1:0])
         2'b00:   step_mask = 10'h3FF;
         2'b01:   step_mask = 10'h00F;
         2'b10:   step_mask = 10'h03F;
         default: step_mask = 10'h0FF;
      endcase
   end

   assign step = tac[2] && ((sys_cnt[9:0] & step_mask) == step_mask);

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         sys_cnt   <= '0;
         tima      <= '0;
         tma       <= '0;
         tac       <= RST_TAC[2:0];
         timer_req <= 1'b0;
      end else begin
         timer_req <= 1'b0;

         if (wr_div)
            sys_cnt <= '0;
         else
            sys_cnt <= sys_cnt + 16'd1;

         if (wr_tac) begin
            tac <= io.wdata[2:0];
         end
         if (wr_tma) begin
            tma <= io.wdata;
         end

         // CPU write beats a step in the same cycle
         if (wr_tima) begin
            tima <= io.wdata;
         end else if (step && !wr_tma) begin
            if (tima == 8'hFF) begin
               tima      <= tma;
               timer_req <= 1'b1;
            end else begin
               tima <= tima + 8'd1;
            end
         end
      end
   end

   // Read mux, zero when another block owns the address
   always_comb begin
      rdata = '0;
      if (!io.re_l) begin
         case (io.addr)
            ADDR_DIV:  rdata = sys_cnt[15:8];
            ADDR_TIMA: rdata = tima;
            ADDR_TMA:  rdata = tma;
            ADDR_TAC:  rdata = {5'b11111, tac};
            default:   rdata = '0;
         endcase
      end
   end

   // Overflow request is a single-cycle pulse
   a_timer_req_pulse: assert property (
      @(posedge clock_in) disable iff (synch_reset) timer_req |=> !timer_req
   );

endmodule

//--- verilog/work_ram.sv
module work_ram (
   input  logic                                 clock_in,
   input  logic [gbc_io_pkg::WRAM_ADDR_BITS-1:0] addr,
   input  gbc_io_pkg::byte_t                    wdata,
   input  logic                                 we_l,
   output gbc_io_pkg::byte_t                    rdata
);
   import gbc_io_pkg::*;

   byte_t mem [WRAM_DEPTH];

   // Read is registered every cycle, lines up with the router read stage
   always_ff @(posedge clock_in) begin
      if (!we_l) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule
